/* logic/stream_pkg.sv */
package stream_pkg;

   // ------------------------------
   // beat field widths
   // ------------------------------
   localparam int TDATA_WID = 32;
   localparam int TKEEP_WID = TDATA_WID / 8;  // one enable per byte
   localparam int TUSER_WID = 4;

   // ------------------------------
   // beat field types
   // ------------------------------

   // payload of one beat
   typedef logic [TDATA_WID-1:0] tdata_t;

   // byte enables, bit i covers tdata[8*i +: 8]
   typedef logic [TKEEP_WID-1:0] tkeep_t;

   typedef logic [TUSER_WID-1:0] tuser_t;  // per-beat sideband, passed through untouched

endpackage

/* logic/buf_pkg.sv */
package buf_pkg;

   // ------------------------------
   // buffer pipeline constants
   // ------------------------------

   // cycles from rd_req to rd_valid
   // ram output register plus one data stage
   localparam int RD_LATENCY = 2;

   // egress output queue, power of two and >= RD_LATENCY + 2
   localparam int SKID_DEPTH = 4;

   // ------------------------------
   // status and control types
   // ------------------------------
   localparam int DROP_CNT_WID = 16;

   typedef logic [DROP_CNT_WID-1:0] drop_count_t;  // saturates at all ones

   typedef enum logic {
      ST_IDLE = 1'b0,  // between packets, nothing in flight
      ST_READ = 1'b1   // packet is being read from the ram
   } egress_state_t;

endpackage

/* logic/pkt_ingress.sv */
module pkt_ingress #(
   parameter int ADDR_WID = 10
) (
   input  logic                  axi4s_in,
   input  logic                  arst_n,

   // input stream, a beat is taken on every edge with s_tvalid high
   input  logic                  s_tvalid,
   input  stream_pkg::tdata_t    s_tdata,
   input  stream_pkg::tkeep_t    s_tkeep,
   input  logic                  s_tlast,
   input  stream_pkg::tuser_t    s_tuser,

   // read side release pointer, from egress
   input  logic [ADDR_WID:0]     free_ptr,

   // ram write port
   output logic                  wr_req,
   output logic [ADDR_WID-1:0]   wr_addr,
   output stream_pkg::tdata_t    wr_tdata,
   output stream_pkg::tkeep_t    wr_tkeep,
   output logic                  wr_tlast,
   output stream_pkg::tuser_t    wr_tuser,

   output logic [ADDR_WID:0]     commit_ptr,  // end of last complete packet
   output buf_pkg::drop_count_t  drop_count
);

   localparam logic [ADDR_WID:0] DEPTH = {1'b1, {ADDR_WID{1'b0}}};

   logic [ADDR_WID:0] wr_ptr;
   logic [ADDR_WID:0] occupancy;
   logic              full;
   logic              discard;   // remaining beats of the current packet are ignored
   logic              overflow;  // beat hits a full buffer

   // ------------------------------
   // space check
   // ------------------------------
   assign occupancy = wr_ptr - free_ptr;  // top pointer bit resolves the wrap
   assign full      = (occupancy == DEPTH);
   assign overflow  = s_tvalid && !discard && full;

   // ------------------------------
   // ram write port
   // ------------------------------
   assign wr_req   = s_tvalid && !discard && !full;
   assign wr_addr  = wr_ptr[ADDR_WID-1:0];
   assign wr_tdata = s_tdata;
   assign wr_tkeep = s_tkeep;
   assign wr_tlast = s_tlast;
   assign wr_tuser = s_tuser;

   // ------------------------------
   // pointers and tail drop
   // ------------------------------
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         discard    <= 1'b0;
      end else if (overflow) begin
         // give back every beat written so far for this packet
         wr_ptr  <= commit_ptr;
         discard <= !s_tlast;   // a last beat ends the packet right here
      end else if (wr_req) begin
         wr_ptr <= wr_ptr + 1'b1;
         if (s_tlast) begin
            commit_ptr <= wr_ptr + 1'b1;  // whole packet now visible to egress
         end
      end else if (s_tvalid && discard && s_tlast) begin
         discard <= 1'b0;
      end
   end

   // one count per dropped packet, held at the top value
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         drop_count <= '0;
      end else if (overflow && (drop_count != '1)) begin
         drop_count <= drop_count + 1'b1;
      end
   end

   // ------------------------------
   // assertions
   // ------------------------------

   // free_ptr comes from egress, so this checks both ends of the buffer
   a_occupancy : assert property (@(posedge axi4s_in) disable iff (!arst_n)
      occupancy <= DEPTH)
      else $error("buffer occupancy above depth");

   a_commit_on_last : assert property (@(posedge axi4s_in) disable iff (!arst_n)
      !(wr_req && wr_tlast) |=> $stable(commit_ptr))
      else $error("commit_ptr moved without a written last beat");

endmodule

/* logic/pkt_ram_buffer.sv */
module pkt_ram_buffer #(
   parameter int ADDR_WID = 10
) (
   input  logic                  axi4s_in,
   input  logic                  arst_n,

   // write port, from ingress
   input  logic                  wr_req,
   input  logic [ADDR_WID-1:0]   wr_addr,
   input  stream_pkg::tdata_t    wr_tdata,
   input  stream_pkg::tkeep_t    wr_tkeep,
   input  logic                  wr_tlast,
   input  stream_pkg::tuser_t    wr_tuser,
   input  logic [ADDR_WID:0]     commit_ptr,

   // read port, from egress
   input  logic                  rd_req,
   input  logic [ADDR_WID-1:0]   rd_addr,

   output logic [ADDR_WID:0]     commit_ptr_p,  // commit_ptr aligned to the write latency
   output logic                  rd_valid,
   output stream_pkg::tdata_t    rd_tdata,
   output stream_pkg::tkeep_t    rd_tkeep,
   output logic                  rd_tlast,
   output stream_pkg::tuser_t    rd_tuser
);

   localparam int DEPTH    = 2**ADDR_WID;
   localparam int WORD_WID = 1 + $bits(stream_pkg::tuser_t) + $bits(stream_pkg::tkeep_t)
                             + $bits(stream_pkg::tdata_t);

   logic [WORD_WID-1:0] mem [DEPTH];
   logic [WORD_WID-1:0] wr_word;
   logic [WORD_WID-1:0] rd_word [buf_pkg::RD_LATENCY];  // stage 0 is the ram output reg
   logic                rd_req_p [buf_pkg::RD_LATENCY];

   // ------------------------------
   // memory array
   // ------------------------------
   assign wr_word = {wr_tlast, wr_tuser, wr_tkeep, wr_tdata};  // one word per beat

   always_ff @(posedge axi4s_in) begin
      if (wr_req) begin
         mem[wr_addr] <= wr_word;
      end
   end

   // read output register and the further data stages
   always_ff @(posedge axi4s_in) begin
      if (rd_req) begin
         rd_word[0] <= mem[rd_addr];
      end
      for (int i = 1; i < buf_pkg::RD_LATENCY; i++) begin
         rd_word[i] <= rd_word[i-1];
      end
   end

   assign {rd_tlast, rd_tuser, rd_tkeep, rd_tdata} = rd_word[buf_pkg::RD_LATENCY-1];

   // ------------------------------
   // valid and pointer pipelines
   // ------------------------------

   // rd_req follows the data through the same number of stages
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < buf_pkg::RD_LATENCY; i++) begin
            rd_req_p[i] <= 1'b0;
         end
      end else begin
         rd_req_p[0] <= rd_req;
         for (int i = 1; i < buf_pkg::RD_LATENCY; i++) begin
            rd_req_p[i] <= rd_req_p[i-1];
         end
      end
   end

   assign rd_valid = rd_req_p[buf_pkg::RD_LATENCY-1];

   // a committed beat is readable one cycle after its write edge
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         commit_ptr_p <= '0;
      end else begin
         commit_ptr_p <= commit_ptr;
      end
   end

   a_no_valid_in_reset : assert property (@(posedge axi4s_in)
      !arst_n |-> !rd_valid)
      else $error("rd_valid high during reset");

endmodule

/* logic/pkt_egress.sv */
module pkt_egress #(
   parameter int ADDR_WID = 10
) (
   input  logic                  axi4s_in,
   input  logic                  arst_n,

   input  logic [ADDR_WID:0]     commit_ptr_p,

   // read data from the buffer, RD_LATENCY after rd_req
   input  logic                  rd_valid,
   input  stream_pkg::tdata_t    rd_tdata,
   input  stream_pkg::tkeep_t    rd_tkeep,
   input  logic                  rd_tlast,
   input  stream_pkg::tuser_t    rd_tuser,

   input  logic                  m_tready,

   output logic                  rd_req,
   output logic [ADDR_WID-1:0]   rd_addr,
   output logic [ADDR_WID:0]     free_ptr,   // slots released back to ingress

   // output stream
   output logic                  m_tvalid,
   output stream_pkg::tdata_t    m_tdata,
   output stream_pkg::tkeep_t    m_tkeep,
   output logic                  m_tlast,
   output stream_pkg::tuser_t    m_tuser
);

   localparam int Q_AW  = $clog2(buf_pkg::SKID_DEPTH);
   localparam int Q_WID = 1 + $bits(stream_pkg::tuser_t) + $bits(stream_pkg::tkeep_t)
                          + $bits(stream_pkg::tdata_t);

   buf_pkg::egress_state_t state;
   buf_pkg::egress_state_t state_nxt;

   logic [ADDR_WID:0] rd_ptr;     // next address to request
   logic [Q_AW:0]     inflight;   // reads issued, data not yet back
   logic [Q_AW:0]     q_count;
   logic [Q_AW-1:0]   q_head;
   logic [Q_AW-1:0]   q_tail;
   logic [Q_WID-1:0]  q_mem [buf_pkg::SKID_DEPTH];
   logic              avail;
   logic              credit;
   logic              rd_issue;
   logic              q_pop;

   // ------------------------------
   // read control
   // ------------------------------
   assign avail    = (rd_ptr != commit_ptr_p);  // complete packets only
   assign credit   = (int'(q_count) + int'(inflight)) < buf_pkg::SKID_DEPTH;
   assign rd_issue = avail && credit;

   always_comb begin
      state_nxt = state;
      case (state)
         buf_pkg::ST_IDLE: begin
            if (rd_issue) begin
               state_nxt = buf_pkg::ST_READ;
            end
         end
         buf_pkg::ST_READ: begin
            // last beat back with nothing behind it
            if (rd_valid && rd_tlast && (inflight == 1) && !rd_issue) begin
               state_nxt = buf_pkg::ST_IDLE;
            end
         end
         default: state_nxt = buf_pkg::ST_IDLE;
      endcase
   end

   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         state    <= buf_pkg::ST_IDLE;
         rd_ptr   <= '0;
         rd_req   <= 1'b0;
         rd_addr  <= '0;
         free_ptr <= '0;
         inflight <= '0;
      end else begin
         state  <= state_nxt;
         rd_req <= rd_issue;
         if (rd_issue) begin
            rd_addr <= rd_ptr[ADDR_WID-1:0];
            rd_ptr  <= rd_ptr + 1'b1;
         end
         // slot is free once the ram has read it
         if (rd_req) begin
            free_ptr <= free_ptr + 1'b1;
         end
         case ({rd_issue, rd_valid})
            2'b10:   inflight <= inflight + 1'b1;
            2'b01:   inflight <= inflight - 1'b1;
            default: inflight <= inflight;
         endcase
      end
   end

   // ------------------------------
   // skid queue
   // ------------------------------
   assign q_pop = m_tvalid && m_tready;

   always_ff @(posedge axi4s_in) begin
      if (rd_valid) begin
         q_mem[q_tail] <= {rd_tlast, rd_tuser, rd_tkeep, rd_tdata};
      end
   end

   // pointers wrap on their own, depth is a power of two
   always_ff @(posedge axi4s_in or negedge arst_n) begin
      if (!arst_n) begin
         q_head  <= '0;
         q_tail  <= '0;
         q_count <= '0;
      end else begin
         if (rd_valid) begin
            q_tail <= q_tail + 1'b1;
         end
         if (q_pop) begin
            q_head <= q_head + 1'b1;
         end
         case ({rd_valid, q_pop})
            2'b10:   q_count <= q_count + 1'b1;
            2'b01:   q_count <= q_count - 1'b1;
            default: q_count <= q_count;
         endcase
      end
   end

   assign m_tvalid = (q_count != '0);
   assign {m_tlast, m_tuser, m_tkeep, m_tdata} = q_mem[q_head];  // head holds until popped

   // ------------------------------
   // assertions
   // ------------------------------
   a_queue_room : assert property (@(posedge axi4s_in) disable iff (!arst_n)
      rd_valid |-> (q_count < buf_pkg::SKID_DEPTH))
      else $error("read data arrived at a full skid queue");

   a_out_stable : assert property (@(posedge axi4s_in) disable iff (!arst_n)
      (m_tvalid && !m_tready) |=>
         (m_tvalid && $stable({m_tdata, m_tkeep, m_tlast, m_tuser})))
      else $error("output changed under back-pressure");

   // idle means the last read of a packet has come back
   a_idle_empty : assert property (@(posedge axi4s_in) disable iff (!arst_n)
      (state == buf_pkg::ST_IDLE) |-> (inflight == '0))
      else $error("egress idle with reads in flight");

endmodule

/* logic/pkt_fifo_top.sv */
module pkt_fifo_top #(
   parameter int ADDR_WID = 10  // depth is 2**ADDR_WID beats
) (
   input  logic                  axi4s_in,
   input  logic                  arst_n,

   // input stream, no back-pressure
   input  logic                  s_tvalid,
   input  stream_pkg::tdata_t    s_tdata,
   input  stream_pkg::tkeep_t    s_tkeep,
   input  logic                  s_tlast,
   input  stream_pkg::tuser_t    s_tuser,

   // output stream
   output logic                  m_tvalid,
   input  logic                  m_tready,
   output stream_pkg::tdata_t    m_tdata,
   output stream_pkg::tkeep_t    m_tkeep,
   output logic                  m_tlast,
   output stream_pkg::tuser_t    m_tuser,

   output buf_pkg::drop_count_t  drop_count
);

   // ------------------------------
   // ingress to buffer
   // ------------------------------
   logic                  wr_req;
   logic [ADDR_WID-1:0]   wr_addr;
   stream_pkg::tdata_t    wr_tdata;
   stream_pkg::tkeep_t    wr_tkeep;
   logic                  wr_tlast;
   stream_pkg::tuser_t    wr_tuser;
   logic [ADDR_WID:0]     commit_ptr;

   // ------------------------------
   // buffer and egress
   // ------------------------------
   logic [ADDR_WID:0]     commit_ptr_p;
   logic                  rd_req;
   logic [ADDR_WID-1:0]   rd_addr;
   logic                  rd_valid;
   stream_pkg::tdata_t    rd_tdata;
   stream_pkg::tkeep_t    rd_tkeep;
   logic                  rd_tlast;
   stream_pkg::tuser_t    rd_tuser;
   logic [ADDR_WID:0]     free_ptr;   // back to ingress for the full test

   pkt_ingress #(.ADDR_WID(ADDR_WID)) u_ingress (
      .axi4s_in, .arst_n,
      .s_tvalid, .s_tdata, .s_tkeep, .s_tlast, .s_tuser,
      .free_ptr,
      .wr_req, .wr_addr, .wr_tdata, .wr_tkeep, .wr_tlast, .wr_tuser,
      .commit_ptr,
      .drop_count
   );

   pkt_ram_buffer #(.ADDR_WID(ADDR_WID)) u_buffer (
      .axi4s_in, .arst_n,
      .wr_req, .wr_addr, .wr_tdata, .wr_tkeep, .wr_tlast, .wr_tuser,
      .commit_ptr,
      .rd_req, .rd_addr,
      .commit_ptr_p,
      .rd_valid, .rd_tdata, .rd_tkeep, .rd_tlast, .rd_tuser
   );

   pkt_egress #(.ADDR_WID(ADDR_WID)) u_egress (
      .axi4s_in, .arst_n,
      .commit_ptr_p,
      .rd_valid, .rd_tdata, .rd_tkeep, .rd_tlast, .rd_tuser,
      .m_tready,
      .rd_req, .rd_addr, .free_ptr,
      .m_tvalid, .m_tdata, .m_tkeep, .m_tlast, .m_tuser
   );

endmodule

/* bench/pkt_fifo_tb.sv */
module pkt_fifo_tb;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ADDR_WID     = 4;    // 16 beats
   localparam int RESET_CYCLES = 20;
   localparam int DRAIN_CYCLES = 400;

   typedef struct packed {
      stream_pkg::tdata_t data;
      stream_pkg::tkeep_t keep;
      stream_pkg::tuser_t user;
      logic               last;
   } beat_t;

   logic                 axi4s_in;
   logic                 arst_n;
   logic                 s_tvalid;
   stream_pkg::tdata_t   s_tdata;
   stream_pkg::tkeep_t   s_tkeep;
   logic                 s_tlast;
   stream_pkg::tuser_t   s_tuser;
   logic                 m_tvalid;
   logic                 m_tready;
   stream_pkg::tdata_t   m_tdata;
   stream_pkg::tkeep_t   m_tkeep;
   logic                 m_tlast;
   stream_pkg::tuser_t   m_tuser;
   buf_pkg::drop_count_t drop_count;

   beat_t                expect_q [$];     // beats of kept packets, in input order
   buf_pkg::drop_count_t exp_drops = '0;
   int                   errors = 0;
   int                   tests = 0;
   int                   beats_out = 0;
   int                   test_num = 0;
   int                   test_start_errs = 0;
   string                test_name;
   int                   ready_mode = 0;   // 0 high, 1 low, 2 random
   logic                 stalled = 1'b0;
   beat_t                held;

   pkt_fifo_top #(.ADDR_WID(ADDR_WID)) DUT (
      .axi4s_in, .arst_n,
      .s_tvalid, .s_tdata, .s_tkeep, .s_tlast, .s_tuser,
      .m_tvalid, .m_tready, .m_tdata, .m_tkeep, .m_tlast, .m_tuser,
      .drop_count
   );

   // ------------------------------
   // clock, reset, m_tready
   // ------------------------------
   initial begin
      axi4s_in = 1'b0;
      forever #2 axi4s_in = ~axi4s_in;
   end

   initial begin
      arst_n = 1'b0;
      repeat (4) @(posedge axi4s_in);
      #1 arst_n = 1'b1;
   end

   initial begin
      void'($urandom(25));
      m_tready = 1'b1;
      forever begin
         @(posedge axi4s_in);
         #1;
         case (ready_mode)
            0:       m_tready = 1'b1;
            1:       m_tready = 1'b0;
            default: m_tready = ($urandom % 2) == 1;
         endcase
      end
   end

   // ------------------------------
   // compare tasks
   // ------------------------------
   task automatic check_beat(input stream_pkg::tdata_t data, input stream_pkg::tkeep_t keep,
                             input stream_pkg::tuser_t user, input logic last, input beat_t exp);
      if ({data, keep, user, last} !== exp) begin
         $display("ERR %0t: beat got %h/%h/%h/%b expected %h/%h/%h/%b", $time,
                  data, keep, user, last, exp.data, exp.keep, exp.user, exp.last);
         errors++;
      end
   endtask

   task automatic check_drops(input buf_pkg::drop_count_t got, input buf_pkg::drop_count_t exp);
      if (got !== exp) begin
         $display("ERR %0t: drop_count got %0d expected %0d", $time, got, exp);
         errors++;
      end
   endtask

   task automatic check_valid(input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERR %0t: m_tvalid got %b expected %b", $time, got, exp);
         errors++;
      end
   endtask

   // ------------------------------
   // output monitor
   // ------------------------------
   always @(posedge axi4s_in) begin
      if (arst_n) begin
         if (stalled && !(m_tvalid && {m_tdata, m_tkeep, m_tuser, m_tlast} === held)) begin
            $display("ERR %0t: output changed while stalled", $time);
            errors++;
         end
         if (m_tvalid && m_tready) begin
            beats_out++;
            if (expect_q.size() == 0) begin
               $display("ERR %0t: beat %h came out with none expected", $time, m_tdata);
               errors++;
            end else begin
               check_beat(m_tdata, m_tkeep, m_tuser, m_tlast, expect_q.pop_front());
            end
         end
         stalled = m_tvalid && !m_tready;
         held    = {m_tdata, m_tkeep, m_tuser, m_tlast};
      end
   end

   // ------------------------------
   // stimulus helpers
   // ------------------------------
   task automatic send_beat(input stream_pkg::tdata_t data, input stream_pkg::tkeep_t keep,
                            input logic last, input stream_pkg::tuser_t user, input logic kept);
      @(posedge axi4s_in);
      #1;
      s_tvalid = 1'b1;
      s_tdata  = data;
      s_tkeep  = keep;
      s_tlast  = last;
      s_tuser  = user;
      if (kept) begin
         expect_q.push_back({data, keep, user, last});
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge axi4s_in);
         #1 s_tvalid = 1'b0;
      end
   endtask

   task automatic drain_output(output logic timed_out);
      int cycles;
      cycles = 0;
      idle_cycles(1);
      while (expect_q.size() != 0 && cycles < DRAIN_CYCLES) begin
         @(negedge axi4s_in);
         cycles++;
      end
      timed_out = (expect_q.size() != 0);
      if (timed_out) begin
         $display("drain wait expired with %0d beats still expected", expect_q.size());
         errors++;
      end else begin
         check_drops(drop_count, exp_drops);
      end
   endtask

   task automatic close_test();
      if (test_num != 0) begin
         tests++;
         if (errors == test_start_errs) begin
            $display("test %0d %0s: ok", test_num, test_name);
         end else begin
            $display("test %0d %0s: %0d errors", test_num, test_name, errors - test_start_errs);
         end
      end
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      int                 fd;
      int                 n;
      int                 cycles;
      int                 pkt;
      int                 last;
      int                 rep;
      string              line;
      string              kind;
      string              word;
      string              fate;
      stream_pkg::tdata_t data;
      stream_pkg::tkeep_t keep;
      stream_pkg::tuser_t user;
      logic               abort;

      s_tvalid = 1'b0;
      s_tdata  = '0;
      s_tkeep  = '0;
      s_tlast  = 1'b0;
      s_tuser  = '0;
      abort    = 1'b0;

      // reset state, checked every cycle until release and once after
      test_num  = 1;
      test_name = "reset_state";
      cycles    = 0;
      while (arst_n !== 1'b1 && cycles < RESET_CYCLES) begin
         @(negedge axi4s_in);
         check_valid(m_tvalid, 1'b0);
         check_drops(drop_count, '0);
         cycles++;
      end
      if (arst_n !== 1'b1) begin
         $display("reset release wait expired");
         errors++;
         abort = 1'b1;
      end
      @(negedge axi4s_in);
      check_valid(m_tvalid, 1'b0);
      check_drops(drop_count, '0);

      fd = $fopen("bench/pkt_stimulus.txt", "r");
      if (fd == 0) begin
         $display("could not open bench/pkt_stimulus.txt");
         errors++;
         abort = 1'b1;
      end
      while (!abort && !$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         n = $sscanf(line, "%s", kind);
         if (n != 1 || kind == "#") begin
            // blank or comment line
         end else if (kind == "test") begin
            close_test();
            void'($sscanf(line, "%s %d %s", kind, test_num, test_name));
            test_start_errs = errors;
         end else if (kind == "mode") begin
            void'($sscanf(line, "%s %s", kind, word));
            ready_mode = (word == "high") ? 0 : (word == "low") ? 1 : 2;
         end else if (kind == "beat") begin
            rep = 1;
            void'($sscanf(line, "%s %d %h %h %d %h %s %d",
                          kind, pkt, data, keep, last, user, fate, rep));
            for (int i = 0; i < rep; i++) begin
               send_beat(data + stream_pkg::tdata_t'(i), keep, (last != 0) && (i == rep - 1),
                         user, fate == "k");
            end
            if (fate == "d" && last != 0) begin
               exp_drops++;   // one count per dropped packet
            end
         end else if (kind == "idle") begin
            void'($sscanf(line, "%s %d", kind, n));
            idle_cycles(n);
         end else if (kind == "drain") begin
            drain_output(abort);
         end else if (kind == "drops") begin
            void'($sscanf(line, "%s %d", kind, n));
            check_drops(drop_count, buf_pkg::drop_count_t'(n));
         end else begin
            $display("unknown stimulus line: %0s", line);
            errors++;
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      close_test();

      $display("tests %0d, beats out %0d, errors %0d", tests, beats_out, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

/* build.f */
logic/stream_pkg.sv
logic/buf_pkg.sv
logic/pkt_ingress.sv
logic/pkt_ram_buffer.sv
logic/pkt_egress.sv
logic/pkt_fifo_top.sv
bench/pkt_fifo_tb.sv

/* bench/pkt_stimulus.txt */
# beat <pkt> <tdata> <tkeep> <tlast> <tuser> <fate k|d> [<beats>], tdata counts up per beat
# idle <cycles>, mode high|low|random, drain, test <n> <name>, drops <final count>
test 2 single_packet
mode high
beat 1 a1000000 f 0 1 k
beat 1 a1000001 3 0 2 k
beat 1 a1000002 1 1 3 k
drain
test 3 back_to_back
beat 2 b2000000 f 1 4 k 4
beat 3 b3000000 7 1 5 k 5
beat 4 b4000000 c 1 6 k 3
beat 5 b5000000 f 1 7 k 2
drain
test 4 back_pressure
mode low
beat 6 c6000000 f 0 8 k 5
beat 6 c6000005 3 1 9 k
beat 7 c7000000 f 1 a k 6
beat 8 c8000000 1 1 b k 4
idle 10
mode random
drain
test 5 oversize_drop
mode high
beat 9 d9000000 f 1 c d 20
idle 2
drain
test 6 recovery
beat 10 ea000000 f 0 e k 2
beat 10 ea000002 8 1 f k
mode random
beat 11 eb000000 f 1 0 k 3
drain
drops 1
